//--- common/mult_pkg.sv
package mult_pkg;

    // operand and product widths
    localparam int OP_WIDTH = 8;
    localparam int PROD_WIDTH = 2 * OP_WIDTH;

    // one partial-product row per multiplier bit
    localparam int PP_ROWS = OP_WIDTH;
    // rows left after the first reduction stage
    localparam int STAGE_ROWS = PP_ROWS / 2;

    typedef logic [OP_WIDTH-1:0] operand_t;
    typedef logic [PROD_WIDTH-1:0] product_t;

    // row k holds a * b[k], already shifted k columns up
    typedef product_t [PP_ROWS-1:0] pp_matrix_t;

    // 0: low sums, 1: low carries, 2: high carries, 3: high sums
    typedef product_t [STAGE_ROWS-1:0] stage_rows_t;

    // returns {carry, sum} of two bits
    function automatic logic [1:0] half_add
    (
        input logic x,
        input logic y
    );
        return {x & y, x ^ y};
    endfunction

    // returns {carry, sum} of three bits
    function automatic logic [1:0] full_add
    (
        input logic x,
        input logic y,
        input logic z
    );
        // majority gives the carry
        return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

endpackage

//--- common/stage_rows_if.sv
`timescale 1ns/1ps

interface stage_rows_if ();
    import mult_pkg::*;

    // sums and pass-through bits at their own column weight
    product_t row0;
    product_t row3;
    // carries, one column heavier than their index
    product_t row1;
    product_t row2;

    // first stage writes all four rows
    modport producer
    (
        output row0,
        output row1,
        output row2,
        output row3
    );

    // second stage aligns and compresses them
    modport consumer
    (
        input row0,
        input row1,
        input row2,
        input row3
    );

endinterface

//--- reduction/compressor_4_2.sv
`timescale 1ns/1ps

module compressor_4_2
(
    input  logic [3:0] p,
    input  logic       cin,
    output logic       sum,
    output logic       carry,
    output logic       cout
);
    import mult_pkg::*;

    // sum of the first three inputs
    logic inner_sum;

    // first adder takes only column bits
    // so cout never waits on cin
    assign {cout, inner_sum} = full_add(p[0], p[1], p[2]);

    // second adder folds in the last bit and the incoming carry
    assign {carry, sum} = full_add(inner_sum, p[3], cin);

    // p0+p1+p2+p3+cin == sum + 2*(carry + cout)

endmodule

//--- reduction/compressor_5_2.sv
`timescale 1ns/1ps

module compressor_5_2
(
    input  logic [4:0] p,
    input  logic       cin1,
    input  logic       cin2,
    output logic       sum,
    output logic       carry,
    output logic       cout1,
    output logic       cout2
);
    import mult_pkg::*;

    // partial sums along the adder chain
    logic sum_a;
    logic sum_b;

    // both outgoing carries come from column bits only
    assign {cout1, sum_a} = full_add(p[0], p[1], p[2]);
    assign {cout2, sum_b} = full_add(sum_a, p[3], p[4]);

    // last adder takes the two carries from the column below
    assign {carry, sum} = full_add(sum_b, cin1, cin2);

    // seven bits in, weight 1 sum plus three weight 2 bits out
    // p0..p4+cin1+cin2 == sum + 2*(carry + cout1 + cout2)

endmodule

//--- reduction/first_stage_reduce.sv
`timescale 1ns/1ps

module first_stage_reduce
(
    input mult_pkg::pp_matrix_t pp,
    stage_rows_if.producer      rows
);
    import mult_pkg::*;

    // column view of the matrix, col[c][r] is row r at column c
    logic [PROD_WIDTH-1:0][PP_ROWS-1:0] col;

    // reduced rows before they go onto the interface
    wire stage_rows_t stage;

    // inter-column carries, chain1 from low rows, chain2 from high rows
    wire [PROD_WIDTH:0] chain1;
    wire [PROD_WIDTH:0] chain2;

    always_comb
    begin
        for (int c = 0; c < PROD_WIDTH; c++)
        begin
            for (int r = 0; r < PP_ROWS; r++)
            begin
                col[c][r] = pp[r][c];
            end
        end
    end

    // nothing enters below column 0
    assign chain1[0] = 1'b0;
    assign chain2[0] = 1'b0;

    genvar i;

    for (i = 0; i < PROD_WIDTH; i++)
    begin : g_col
        if (i == 0)
        begin : g_pass
            // single bit, passed straight through
            assign stage[0][i] = col[i][0];
            assign stage[1][i] = 1'b0;
            assign stage[2][i] = 1'b0;
            assign stage[3][i] = 1'b0;
            assign chain1[i+1] = 1'b0;
            assign chain2[i+1] = 1'b0;
        end
        else if (i == 1)
        begin : g_half
            assign {stage[1][i], stage[0][i]} = half_add(col[i][0], col[i][1]);
            assign stage[2][i] = 1'b0;
            assign stage[3][i] = 1'b0;
            assign chain1[i+1] = 1'b0;
            assign chain2[i+1] = 1'b0;
        end
        else if (i == 2)
        begin : g_full
            assign {stage[1][i], stage[0][i]} = full_add(col[i][0], col[i][1], col[i][2]);
            assign stage[2][i] = 1'b0;
            assign stage[3][i] = 1'b0;
            assign chain1[i+1] = 1'b0;
            assign chain2[i+1] = 1'b0;
        end
        else if (i < OP_WIDTH - 1)
        begin : g_low
            // rows 0..3 through a 4:2, chain1 starts here with a zero input
            compressor_4_2 u_comp_lo
            (
                .p     (col[i][3:0]),
                .cin   (chain1[i]),
                .sum   (stage[0][i]),
                .carry (stage[1][i]),
                .cout  (chain1[i+1])
            );
            assign chain2[i+1] = 1'b0;

            // rows 4 and up, as many as this column holds
            if (i == 3)
            begin : g_up_none
                assign stage[2][i] = 1'b0;
                assign stage[3][i] = 1'b0;
            end
            else if (i == 4)
            begin : g_up_pass
                assign stage[2][i] = 1'b0;
                assign stage[3][i] = col[i][4];
            end
            else if (i == 5)
            begin : g_up_half
                assign {stage[2][i], stage[3][i]} = half_add(col[i][4], col[i][5]);
            end
            else
            begin : g_up_full
                assign {stage[2][i], stage[3][i]} = full_add(col[i][4], col[i][5], col[i][6]);
            end
        end
        else if (i == OP_WIDTH - 1)
        begin : g_mid
            // full column of eight, two 4:2 side by side
            compressor_4_2 u_comp_lo
            (
                .p     (col[i][3:0]),
                .cin   (chain1[i]),
                .sum   (stage[0][i]),
                .carry (stage[1][i]),
                .cout  (chain1[i+1])
            );
            // chain2 is still zero here, it starts with this cout
            compressor_4_2 u_comp_hi
            (
                .p     (col[i][7:4]),
                .cin   (chain2[i]),
                .sum   (stage[3][i]),
                .carry (stage[2][i]),
                .cout  (chain2[i+1])
            );
        end
        else
        begin : g_high
            // upper five rows plus both chains
            compressor_5_2 u_comp
            (
                .p     (col[i][7:3]),
                .cin1  (chain1[i]),
                .cin2  (chain2[i]),
                .sum   (stage[0][i]),
                .carry (stage[1][i]),
                .cout1 (chain1[i+1]),
                .cout2 (chain2[i+1])
            );
            // remaining three rows, the low ones may be zero
            assign {stage[2][i], stage[3][i]} = full_add(col[i][0], col[i][1], col[i][2]);
        end
    end

    // carries out of column 15 are always zero, product fits in 16 bits
    assign rows.row0 = stage[0];
    assign rows.row1 = stage[1];
    assign rows.row2 = stage[2];
    assign rows.row3 = stage[3];

endmodule

//--- reduction/second_stage_reduce.sv
`timescale 1ns/1ps

module second_stage_reduce
(
    stage_rows_if.consumer      rows,
    output mult_pkg::product_t  sum_row,
    output mult_pkg::product_t  carry_row
);
    import mult_pkg::*;

    // carry rows moved to their true column weight
    product_t carry_lo_aligned;
    product_t carry_hi_aligned;

    // column to column carry of the 4:2 row
    wire [PROD_WIDTH:0] ripple;

    // top bit shifted out is zero for any 8x8 product
    assign carry_lo_aligned = rows.row1 << 1;
    assign carry_hi_aligned = rows.row2 << 1;

    assign ripple[0] = 1'b0;

    genvar j;

    for (j = 0; j < PROD_WIDTH; j++)
    begin : g_col
        // four aligned bits in, sum stays, carry weighs one column more
        compressor_4_2 u_comp
        (
            .p     ({rows.row0[j], carry_lo_aligned[j], carry_hi_aligned[j], rows.row3[j]}),
            .cin   (ripple[j]),
            .sum   (sum_row[j]),
            .carry (carry_row[j]),
            .cout  (ripple[j+1])
        );
    end

    // ripple[16] dropped
    // carry_row still needs a one column shift before the final add

endmodule

//--- hdl/pp_generate.sv
`timescale 1ns/1ps

module pp_generate
(
    input  mult_pkg::operand_t   a,
    input  mult_pkg::operand_t   b,
    output mult_pkg::pp_matrix_t pp
);
    import mult_pkg::*;

    always_comb
    begin
        for (int k = 0; k < PP_ROWS; k++)
        begin
            // a gated by multiplier bit k
            // widened first so the shift keeps the high bits
            pp[k] = product_t'(a & {OP_WIDTH{b[k]}}) << k;
        end
    end

    // columns below k and above k+7 stay zero in row k

endmodule

//--- hdl/dadda_mult_top.sv
`timescale 1ns/1ps

module dadda_mult_top
(
    input  logic               clk,
    input  logic               rst,
    input  mult_pkg::operand_t a,
    input  mult_pkg::operand_t b,
    output mult_pkg::product_t product
);
    import mult_pkg::*;

    // operand register
    operand_t a_q;
    operand_t b_q;

    // partial products of the registered operands
    pp_matrix_t pp;

    // two rows left after the tree
    product_t sum_row;
    product_t carry_row;

    // final carry-propagate sum
    product_t product_d;

    // four rows between the two reduction stages
    stage_rows_if rows_if ();

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_q <= '0;
            b_q <= '0;
        end
        else
        begin
            a_q <= a;
            b_q <= b;
        end
    end

    pp_generate u_pp_generate
    (
        .a  (a_q),
        .b  (b_q),
        .pp (pp)
    );

    // eight rows down to four
    first_stage_reduce u_first_stage
    (
        .pp   (pp),
        .rows (rows_if.producer)
    );

    // four rows down to two
    second_stage_reduce u_second_stage
    (
        .rows      (rows_if.consumer),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    // carry row weighs one column more than its index
    assign product_d = sum_row + (carry_row << 1);

    // product register, result two edges after the operands are sampled
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            product <= '0;
        end
        else
        begin
            product <= product_d;
        end
    end

endmodule

//--- testbench/tb_dadda_mult.sv
`timescale 1ns/1ps

module tb_dadda_mult;
    import mult_pkg::*;

    // cycle limit for any single wait loop
    localparam int WAIT_LIMIT = 20;
    localparam int RANDOM_PAIRS = 300;
    localparam int PIPE_PAIRS = 50;

    logic clk;
    logic rst;
    operand_t a;
    operand_t b;
    product_t product;

    int checks;
    int errors;
    int timeouts;

    // lcg state, fixed seed
    logic [31:0] rng_state;

    dadda_mult_top dut_i
    (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .b       (b),
        .product (product)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // reset for four rising edges, released on a falling edge
    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        // operands back to zero together with the release
        a <= '0;
        b <= '0;
    end

    // numerical recipes lcg constants
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // count rising edges, then settle on the falling edge
    task automatic wait_edges(input int edges);
        int seen;
        int guard;
        seen = 0;
        guard = 0;
        while (seen < edges && guard < WAIT_LIMIT)
        begin
            @(posedge clk);
            seen++;
            guard++;
        end
        if (seen < edges)
        begin
            $display("timeout while waiting for %0d clock edges at %0t", edges, $time);
            timeouts++;
        end
        @(negedge clk);
    endtask

    // product sampled mid-cycle, away from the register update
    task automatic check_product(input product_t expected);
        checks++;
        if (product !== expected)
        begin
            $display("Fail at %0t: product expected %0d got %0d", $time, expected, product);
            errors++;
        end
    endtask

    // operands held for one sample, result read two edges later
    task automatic apply_and_check(input operand_t x, input operand_t y);
        a = x;
        b = y;
        wait_edges(2);
        check_product(product_t'(x) * product_t'(y));
    endtask

    // product held at zero through reset and right after it
    task automatic test_reset();
        int guard;
        guard = 0;
        // rst may still be unknown at time zero
        while (rst !== 1'b0 && guard < WAIT_LIMIT)
        begin
            @(negedge clk);
            check_product('0);
            guard++;
        end
        if (rst !== 1'b0)
        begin
            $display("timeout while waiting for reset release at %0t", $time);
            timeouts++;
        end
        // zero operands still in the pipe
        wait_edges(1);
        check_product('0);
    endtask

    // all pairings of the edge values
    task automatic test_corners();
        operand_t corner [4];
        corner[0] = 8'd0;
        corner[1] = 8'd1;
        corner[2] = 8'd255;
        corner[3] = 8'd128;
        for (int i = 0; i < 4; i++)
        begin
            for (int j = 0; j < 4; j++)
            begin
                apply_and_check(corner[i], corner[j]);
            end
        end
        // largest product, high columns and both chains busy
        a = 8'd255;
        b = 8'd255;
        wait_edges(2);
        check_product(16'd65025);
    endtask

    // one-hot times one-hot lands on a single bit
    task automatic test_walking_bits();
        for (int i = 0; i < OP_WIDTH; i++)
        begin
            for (int j = 0; j < OP_WIDTH; j++)
            begin
                a = operand_t'(1) << i;
                b = operand_t'(1) << j;
                wait_edges(2);
                check_product(product_t'(1) << (i + j));
            end
        end
    endtask

    // one pair at a time
    task automatic test_random();
        logic [31:0] r;
        for (int n = 0; n < RANDOM_PAIRS; n++)
        begin
            r = next_random();
            // upper lcg bits, the low ones cycle quickly
            apply_and_check(r[23:16], r[31:24]);
        end
    endtask

    // new pair every cycle, two results in flight
    task automatic test_pipelined();
        product_t expected_q [$];
        logic [31:0] r;
        operand_t x;
        operand_t y;
        for (int k = 0; k < PIPE_PAIRS + 2; k++)
        begin
            // pair from two cycles back is due now
            if (k >= 2)
            begin
                if (expected_q.size() != 2)
                begin
                    $display("pipeline test lost track of the pairs in flight at %0t", $time);
                    errors++;
                end
                check_product(expected_q.pop_front());
            end
            if (k < PIPE_PAIRS)
            begin
                r = next_random();
                x = r[23:16];
                y = r[31:24];
            end
            else
            begin
                // zeros flush the last two pairs out
                x = '0;
                y = '0;
            end
            a = x;
            b = y;
            expected_q.push_back(product_t'(x) * product_t'(y));
            wait_edges(1);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        // nonzero during reset, so only the reset keeps product at zero
        a = 8'd255;
        b = 8'd255;
        checks = 0;
        errors = 0;
        timeouts = 0;
        rng_state = 32'd7559;

        test_reset();
        test_corners();
        test_walking_bits();
        test_random();
        test_pipelined();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb.f
common/mult_pkg.sv
common/stage_rows_if.sv
reduction/compressor_4_2.sv
reduction/compressor_5_2.sv
reduction/first_stage_reduce.sv
reduction/second_stage_reduce.sv
hdl/pp_generate.sv
hdl/dadda_mult_top.sv
testbench/tb_dadda_mult.sv

//--- Bender.yml
package:
  name: dadda_mult

sources:
  # shared package and interface first
  - common/mult_pkg.sv
  - common/stage_rows_if.sv
  # reduction tree
  - reduction/compressor_4_2.sv
  - reduction/compressor_5_2.sv
  - reduction/first_stage_reduce.sv
  - reduction/second_stage_reduce.sv
  # remaining RTL and top level
  - hdl/pp_generate.sv
  - hdl/dadda_mult_top.sv
  # testbench
  - target: test
    files:
      - testbench/tb_dadda_mult.sv
